// ==== hdl/denise_reg_pkg.sv ====
`default_nettype none

package denise_reg_pkg;

  // -------------------------------------------------------------------------
  // chip bus register map
  // -------------------------------------------------------------------------

  // the bus carries address bits 8 to 1, so word addresses are halved
  typedef logic [7:0] reg_addr_t;

  // control registers
  localparam reg_addr_t BPLCON0 = 8'h80;  // 0x100, mode control
  localparam reg_addr_t BPLCON1 = 8'h81;  // 0x102, horizontal scroll
  localparam reg_addr_t BPLCON2 = 8'h82;  // 0x104, priority control

  // bitplane data registers
  // writing BPL1DAT starts a new word on all planes
  localparam reg_addr_t BPL1DAT = 8'h88;  // 0x110
  localparam reg_addr_t BPL2DAT = 8'h89;  // 0x112
  localparam reg_addr_t BPL3DAT = 8'h8A;  // 0x114
  localparam reg_addr_t BPL4DAT = 8'h8B;  // 0x116
  localparam reg_addr_t BPL5DAT = 8'h8C;  // 0x118
  localparam reg_addr_t BPL6DAT = 8'h8D;  // 0x11A

  // -------------------------------------------------------------------------
  // control bit positions
  // -------------------------------------------------------------------------

  localparam int HIRES_BIT  = 15;  // BPLCON0, 1 = one pixel per tick
  localparam int DPF_BIT    = 10;  // BPLCON0, dual playfield enable
  localparam int PF2PRI_BIT = 6;   // BPLCON2, playfield 2 in front

  // scroll fields inside BPLCON1
  localparam int PF1H_LSB = 0;  // odd planes, bits 3:0
  localparam int PF2H_LSB = 4;  // even planes, bits 7:4

endpackage

`default_nettype wire

// ==== hdl/denise_video_pkg.sv ====
`default_nettype none

package denise_video_pkg;

  // -------------------------------------------------------------------------
  // video path data types
  // -------------------------------------------------------------------------

  typedef logic [15:0] bus_word_t;    // one bitplane word, MSB shown first
  typedef logic [3:0]  scroll_t;      // delay in shift steps, 0 to 15
  typedef logic [5:0]  color_index_t; // colour register number

  // ocs limit, planes above this do not exist
  localparam int MAX_PLANES = 6;

  // planes per playfield in dual mode
  // pf1 = planes 1,3,5 and pf2 = planes 2,4,6
  localparam int PF_BITS = 3;

  // in dual mode playfield 2 uses the upper half of the
  // first sixteen colour registers
  localparam color_index_t PF2_COLOR_BASE = 6'd8;

endpackage

`default_nettype wire

// ==== hdl/denise_bitplane_shifter.sv ====
`timescale 1ns/10ps
`default_nettype none

// parallel-to-serial converter for a single bitplane
// the word is loaded in one tick, then shifted out MSB first, either
// every tick (hires) or every second tick (lores); the serial stream is
// delayed by the scroll value through a short history line
module denise_bitplane_shifter (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        clk7_en,  // 7 MHz tick
  input  logic                        load,     // one tick pulse, new word
  input  logic                        hires,    // 1 = shift every tick
  input  denise_video_pkg::bus_word_t data_in,  // buffered plane word
  input  denise_video_pkg::scroll_t   scroll,   // captured at load upstream
  output logic                        out       // serial plane bit
);

  import denise_video_pkg::*;

  localparam int WORD_BITS  = $bits(bus_word_t);
  localparam int HIST_DEPTH = (1 << $bits(scroll_t)) - 1;  // 15 older MSBs

  bus_word_t               shift_reg;    // pixels still to be shown
  logic                    lores_phase;  // second half of a lores pixel
  logic [HIST_DEPTH-1:0]   history;      // previous MSBs, newest in bit 0
  logic [HIST_DEPTH:0]     taps;         // tap 0 is the live MSB
  logic                    shift_step;

  // a load tick never shifts; lores waits for the second tick of a pixel
  assign shift_step = clk7_en && !load && (hires || lores_phase);

  // -------------------------------------------------------------------------
  // shift register and lores phase
  // -------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      shift_reg   <= '0;
      lores_phase <= 1'b0;
    end else if (clk7_en) begin
      if (load) begin
        shift_reg   <= data_in;  // parallel load
        lores_phase <= 1'b0;     // first pixel gets its full two ticks
      end else begin
        lores_phase <= ~lores_phase;
        if (shift_step)
          shift_reg <= {shift_reg[WORD_BITS-2:0], 1'b0};  // zeros in at lsb
      end
    end
  end

  // -------------------------------------------------------------------------
  // scroll delay line
  // -------------------------------------------------------------------------

  // every shift pushes the outgoing MSB into the history, so the history
  // moves at pixel rate and a scroll count is a count of pixels
  always_ff @(posedge clk) begin
    if (reset)
      history <= '0;  // blank pixels ahead of the first word
    else if (shift_step)
      history <= {history[HIST_DEPTH-2:0], shift_reg[WORD_BITS-1]};
  end

  assign taps = {history, shift_reg[WORD_BITS-1]};
  assign out  = taps[scroll];  // scroll 0 shows the live MSB

  // load comes from a tick-enabled register, so it may only rise just
  // after a tick; anything else means a broken enable upstream
  a_load_after_tick : assert property (
    @(posedge clk) disable iff (reset)
    $rose(load) |-> $past(clk7_en)
  );

endmodule

`default_nettype wire

// ==== hdl/denise_bitplanes.sv ====
`timescale 1ns/10ps
`default_nettype none

// bitplane register block
// decodes chip bus writes, keeps the control registers and one buffer
// word per plane, and feeds the shifter array; a write to BPL1DAT
// starts all planes together one tick later
module denise_bitplanes #(
  parameter int NUM_PLANES = 6
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        clk7_en,         // 7 MHz tick
  input  denise_reg_pkg::reg_addr_t   reg_address_in,  // address bits 8:1
  input  denise_video_pkg::bus_word_t data_in,         // bus write data
  output logic [NUM_PLANES-1:0]       bpldata,         // plane 1 in bit 0
  output logic                        hires,           // BPLCON0 hires
  output logic                        dpf,             // BPLCON0 dual pf
  output logic                        pf2pri           // BPLCON2 pf2 front
);

  import denise_reg_pkg::*;
  import denise_video_pkg::*;

  // data register of each plane, plane 1 first
  localparam reg_addr_t BPL_DAT_ADDR [MAX_PLANES] = '{
    BPL1DAT, BPL2DAT, BPL3DAT, BPL4DAT, BPL5DAT, BPL6DAT
  };

  logic    load;          // high for the tick after a BPL1DAT write
  scroll_t bplcon1_pf1h;  // BPLCON1 odd plane scroll as written
  scroll_t bplcon1_pf2h;  // BPLCON1 even plane scroll as written
  scroll_t pf1h;          // odd plane scroll in use for the current word
  scroll_t pf2h;          // even plane scroll in use for the current word

  // -------------------------------------------------------------------------
  // control registers
  // -------------------------------------------------------------------------

  // only the fields the playfield path uses are kept
  always_ff @(posedge clk) begin
    if (reset) begin
      hires        <= 1'b0;  // lores, single playfield after reset
      dpf          <= 1'b0;
      pf2pri       <= 1'b0;
      bplcon1_pf1h <= '0;
      bplcon1_pf2h <= '0;
    end else if (clk7_en) begin
      case (reg_address_in)
        BPLCON0: begin
          hires <= data_in[HIRES_BIT];
          dpf   <= data_in[DPF_BIT];
        end
        BPLCON1: begin
          bplcon1_pf1h <= data_in[PF1H_LSB +: $bits(scroll_t)];
          bplcon1_pf2h <= data_in[PF2H_LSB +: $bits(scroll_t)];
        end
        BPLCON2: pf2pri <= data_in[PF2PRI_BIT];
        default: ;  // other registers belong elsewhere
      endcase
    end
  end

  // -------------------------------------------------------------------------
  // load pulse and scroll capture
  // -------------------------------------------------------------------------

  // load follows the BPL1DAT write by one tick, so the plane 1 buffer
  // already holds the new word when the shifters take it
  always_ff @(posedge clk) begin
    if (reset)
      load <= 1'b0;
    else if (clk7_en)
      load <= (reg_address_in == BPL1DAT);
  end

  // scroll is frozen per word, a BPLCON1 write mid-line waits for the
  // next load
  always_ff @(posedge clk) begin
    if (reset) begin
      pf1h <= '0;
      pf2h <= '0;
    end else if (clk7_en && load) begin
      pf1h <= bplcon1_pf1h;
      pf2h <= bplcon1_pf2h;
    end
  end

  // a BPL1DAT write on two ticks in a row would merge two loads
  a_load_single_tick : assert property (
    @(posedge clk) disable iff (reset)
    (clk7_en && load) |=> !load
  );

  // -------------------------------------------------------------------------
  // plane buffers and shifters
  // -------------------------------------------------------------------------

  for (genvar i = 0; i < NUM_PLANES; i++) begin : g_plane
    bus_word_t bpl_dat;  // buffer register, written any time before load

    always_ff @(posedge clk) begin
      if (clk7_en && (reg_address_in == BPL_DAT_ADDR[i]))
        bpl_dat <= data_in;
    end

    // plane i+1: odd planes use pf1 scroll, even planes pf2 scroll
    denise_bitplane_shifter u_shifter (
      .clk     (clk),
      .reset   (reset),
      .clk7_en (clk7_en),
      .load    (load),
      .hires   (hires),
      .data_in (bpl_dat),
      .scroll  ((i % 2 == 0) ? pf1h : pf2h),
      .out     (bpldata[i])
    );
  end

endmodule

`default_nettype wire

// ==== hdl/denise_playfields.sv ====
`timescale 1ns/10ps
`default_nettype none

// playfield combiner
// turns the serial plane bits into a colour register index, either
// straight (single playfield) or as two 3-plane playfields with priority
module denise_playfields #(
  parameter int NUM_PLANES = 6
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           clk7_en,     // 7 MHz tick
  input  logic [NUM_PLANES-1:0]          bpldata,     // plane 1 in bit 0
  input  logic                           dpf,         // dual playfield mode
  input  logic                           pf2pri,      // pf2 in front of pf1
  output denise_video_pkg::color_index_t plfdata,     // registered index
  output logic [1:0]                     nplayfield,  // bit 0 pf1, bit 1 pf2
  output logic                           pix_valid    // first pixel seen
);

  import denise_video_pkg::*;

  logic [MAX_PLANES-1:0] planes;  // missing planes read as 0
  logic [PF_BITS-1:0]    pf1;     // planes 5,3,1
  logic [PF_BITS-1:0]    pf2;     // planes 6,4,2
  logic                  pf1_nz;
  logic                  pf2_nz;
  color_index_t          color;   // index before the output register

  always_comb begin
    planes                 = '0;
    planes[NUM_PLANES-1:0] = bpldata;
  end

  assign pf1    = {planes[4], planes[2], planes[0]};
  assign pf2    = {planes[5], planes[3], planes[1]};
  assign pf1_nz = |pf1;
  assign pf2_nz = |pf2;

  // -------------------------------------------------------------------------
  // priority and index
  // -------------------------------------------------------------------------

  always_comb begin
    if (!dpf)
      color = color_index_t'(planes);  // single playfield, plane 1 = lsb
    else if (pf2pri && pf2_nz)
      color = PF2_COLOR_BASE + color_index_t'(pf2);  // pf2 in front
    else if (pf1_nz)
      color = color_index_t'(pf1);
    else if (pf2_nz)
      color = PF2_COLOR_BASE + color_index_t'(pf2);  // pf2 shows through
    else
      color = '0;  // both transparent, background
  end

  // one tick of latency after the shifter output
  always_ff @(posedge clk) begin
    if (reset) begin
      plfdata    <= '0;
      nplayfield <= '0;
      pix_valid  <= 1'b0;
    end else if (clk7_en) begin
      plfdata    <= color;
      nplayfield <= {pf2_nz, pf1_nz};  // flagged in both modes
      if (|bpldata)
        pix_valid <= 1'b1;  // sticky until reset
    end
  end

  // dual playfield only reaches colours 0 to 15
  a_dpf_index_range : assert property (
    @(posedge clk) disable iff (reset)
    (clk7_en && dpf) |=> (plfdata[5:4] == 2'b00)
  );

endmodule

`default_nettype wire

// ==== hdl/denise_video.sv ====
`timescale 1ns/10ps
`default_nettype none

// playfield video path of the display controller
// bus writes -> bitplane registers and shifters -> playfield combiner
module denise_video #(
  parameter int NUM_PLANES = denise_video_pkg::MAX_PLANES
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           clk7_en,         // 7 MHz tick
  input  denise_reg_pkg::reg_addr_t      reg_address_in,  // address bits 8:1
  input  denise_video_pkg::bus_word_t    data_in,         // bus write data
  output denise_video_pkg::color_index_t plfdata,         // colour index
  output logic [1:0]                     nplayfield,      // pf non-zero flags
  output logic                           pix_valid
);

  import denise_video_pkg::*;

  // plane count is fixed at elaboration, 1 to 6 planes
  if (NUM_PLANES < 1 || NUM_PLANES > MAX_PLANES) begin : g_bad_planes
    $error("NUM_PLANES must be between 1 and %0d", MAX_PLANES);
  end

  logic [NUM_PLANES-1:0] bpldata;  // serial plane bits
  logic                  dpf;
  logic                  pf2pri;

  // -------------------------------------------------------------------------
  // bitplane registers and shifters
  // -------------------------------------------------------------------------

  // hires only paces the shifters inside the block
  denise_bitplanes #(
    .NUM_PLANES (NUM_PLANES)
  ) u_bitplanes (
    .clk            (clk),
    .reset          (reset),
    .clk7_en        (clk7_en),
    .reg_address_in (reg_address_in),
    .data_in        (data_in),
    .bpldata        (bpldata),
    .hires          (),
    .dpf            (dpf),
    .pf2pri         (pf2pri)
  );

  // -------------------------------------------------------------------------
  // playfield combiner
  // -------------------------------------------------------------------------

  denise_playfields #(
    .NUM_PLANES (NUM_PLANES)
  ) u_playfields (
    .clk        (clk),
    .reset      (reset),
    .clk7_en    (clk7_en),
    .bpldata    (bpldata),
    .dpf        (dpf),
    .pf2pri     (pf2pri),
    .plfdata    (plfdata),
    .nplayfield (nplayfield),
    .pix_valid  (pix_valid)
  );

endmodule

`default_nettype wire

// ==== tb/denise_video_tb_ref.svh ====
// reference model of the playfield video path
// stepped once per tick with the bus values the DUT takes on that tick

// ---------------------------------------------------------------------------
// model state
// ---------------------------------------------------------------------------

bus_word_t    m_bpl   [MAX_PLANES];  // plane buffer words
bus_word_t    m_shift [MAX_PLANES];  // pixels still to come, msb next
logic [14:0]  m_hist  [MAX_PLANES];  // earlier msbs, newest in bit 0
logic         m_load;                // tick after a BPL1DAT write
logic         m_phase;               // lores half-pixel phase
logic         m_hires;
logic         m_dpf;
logic         m_pf2pri;
logic         m_valid;
scroll_t      m_c1_pf1;              // BPLCON1 as written
scroll_t      m_c1_pf2;
scroll_t      m_pf1h;                // scroll taken at load
scroll_t      m_pf2h;
color_index_t m_plf;                 // expected plfdata
logic [1:0]   m_npf;                 // expected nplayfield

// colour index rule, returns {pf2 non-zero, pf1 non-zero, index}
function automatic logic [7:0] expected_pixel(input logic [5:0] planes,
                                               input logic dpf_m,
                                               input logic pri_m);
  logic [2:0] p1;
  logic [2:0] p2;
  logic [5:0] idx;
  p1 = {planes[4], planes[2], planes[0]};  // odd planes
  p2 = {planes[5], planes[3], planes[1]};  // even planes
  if (!dpf_m)
    idx = planes;  // plane 1 is the lsb
  else if (pri_m && p2 != 3'd0)
    idx = 6'd8 + {3'd0, p2};
  else if (p1 != 3'd0)
    idx = {3'd0, p1};
  else if (p2 != 3'd0)
    idx = 6'd8 + {3'd0, p2};
  else
    idx = 6'd0;
  return {p2 != 3'd0, p1 != 3'd0, idx};
endfunction

// bit shown by a plane, s shift steps behind the live msb
function automatic logic plane_tap(input bus_word_t sh, input logic [14:0] h,
                                   input scroll_t s);
  if (s == 4'd0)
    return sh[15];
  return h[int'(s) - 1];
endfunction

task automatic model_reset();
  for (int p = 0; p < MAX_PLANES; p++) begin
    m_bpl[p]   = '0;
    m_shift[p] = '0;
    m_hist[p]  = '0;
  end
  m_load   = 1'b0;
  m_phase  = 1'b0;
  m_hires  = 1'b0;
  m_dpf    = 1'b0;
  m_pf2pri = 1'b0;
  m_valid  = 1'b0;
  m_c1_pf1 = '0;
  m_c1_pf2 = '0;
  m_pf1h   = '0;
  m_pf2h   = '0;
  m_plf    = '0;
  m_npf    = '0;
endtask

// one tick: output stage first, then shifters, then registers, all from
// the state before the tick
task automatic model_step(input reg_addr_t a, input bus_word_t d);
  logic [5:0] bits;
  logic [7:0] px;
  logic       step;
  bits = '0;
  for (int p = 0; p < MAX_PLANES; p++)
    bits[p] = plane_tap(m_shift[p], m_hist[p], (p % 2 == 0) ? m_pf1h : m_pf2h);
  px    = expected_pixel(bits, m_dpf, m_pf2pri);
  m_npf = px[7:6];
  m_plf = px[5:0];
  if (|bits)
    m_valid = 1'b1;
  step = !m_load && (m_hires || m_phase);  // lores shifts every second tick
  for (int p = 0; p < MAX_PLANES; p++) begin
    if (m_load) begin
      m_shift[p] = m_bpl[p];
    end else if (step) begin
      m_hist[p]  = {m_hist[p][13:0], m_shift[p][15]};
      m_shift[p] = {m_shift[p][14:0], 1'b0};
    end
  end
  if (m_load) begin
    m_phase = 1'b0;
    m_pf1h  = m_c1_pf1;
    m_pf2h  = m_c1_pf2;
  end else begin
    m_phase = ~m_phase;
  end
  case (a)
    BPLCON0: begin
      m_hires = d[HIRES_BIT];
      m_dpf   = d[DPF_BIT];
    end
    BPLCON1: begin
      m_c1_pf1 = d[3:0];
      m_c1_pf2 = d[7:4];
    end
    BPLCON2: m_pf2pri = d[PF2PRI_BIT];
    default: ;
  endcase
  for (int p = 0; p < MAX_PLANES; p++)
    if (a == reg_addr_t'(int'(BPL1DAT) + p))
      m_bpl[p] = d;  // data registers sit on consecutive word addresses
  m_load = (a == BPL1DAT);
endtask

// ==== tb/denise_video_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module denise_video_tb;

  import denise_reg_pkg::*;
  import denise_video_pkg::*;

  localparam reg_addr_t NOP_ADDR = 8'hFF;  // no register here
  // tick budgets per test, the hires test may spend 4 cycles per tick
  localparam int LEN_TOTAL  = 10 + 20 + 50 + 4 * 40 + 50 + 70 + 70;
  localparam int MAX_CYCLES = 2 * LEN_TOTAL;

  logic         clk = 1'b0;
  logic         reset;
  logic         clk7_en;
  reg_addr_t    reg_address_in;
  bus_word_t    data_in;
  color_index_t plfdata;
  logic [1:0]   nplayfield;
  logic         pix_valid;

  integer seed = 33193;
  int     cycle_count = 0;
  int     pass_count = 0;
  int     fail_count = 0;
  int     fails_at_start;
  logic   gap_en = 1'b0;  // random idle cycles between ticks
  logic   synced = 1'b0;  // model has seen reset

  `include "denise_video_tb_ref.svh"

  always #5 clk = ~clk;  // 10 ns period

  denise_video #(
    .NUM_PLANES (6)
  ) u_denise_video (
    .clk            (clk),
    .reset          (reset),
    .clk7_en        (clk7_en),
    .reg_address_in (reg_address_in),
    .data_in        (data_in),
    .plfdata        (plfdata),
    .nplayfield     (nplayfield),
    .pix_valid      (pix_valid)
  );

  // ---------------------------------------------------------------------------
  // compare process, outputs are stable at the falling edge
  // ---------------------------------------------------------------------------

  always @(negedge clk) begin
    cycle_count++;
    if (cycle_count > MAX_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end else if (reset) begin
      model_reset();
      synced = 1'b1;
    end else if (synced) begin
      assert (plfdata === m_plf && nplayfield === m_npf && pix_valid === m_valid) begin
        pass_count++;
      end else begin
        $display("FAIL t=%0t plfdata/nplayfield/pix_valid exp %h/%b/%b got %h/%b/%b",
                 $time, m_plf, m_npf, m_valid, plfdata, nplayfield, pix_valid);
        fail_count++;
      end
      if (clk7_en)
        model_step(reg_address_in, data_in);  // what the DUT takes next edge
    end
  end

  // ---------------------------------------------------------------------------
  // bus driving
  // ---------------------------------------------------------------------------

  task automatic bus_tick(input reg_addr_t a, input bus_word_t d);
    int n;
    n = gap_en ? ($random(seed) & 3) : 0;
    repeat (n) begin
      @(posedge clk);
      clk7_en        <= 1'b0;  // enable gap, nothing advances
      reg_address_in <= NOP_ADDR;
    end
    @(posedge clk);
    clk7_en        <= 1'b1;
    reg_address_in <= a;
    data_in        <= d;
  endtask

  task automatic idle_ticks(input int n);
    repeat (n) bus_tick(NOP_ADDR, 16'h0000);
  endtask

  // planes 6..2 first, the BPL1DAT write starts the word
  task automatic load_planes();
    for (int p = MAX_PLANES - 1; p >= 0; p--)
      bus_tick(reg_addr_t'(int'(BPL1DAT) + p), bus_word_t'($random(seed)));
  endtask

  task automatic begin_test();
    fails_at_start = fail_count;
  endtask

  task automatic end_test(input string name);
    $display("%s: %0s", name, (fail_count == fails_at_start) ? "ok" : "mismatches seen");
  endtask

  // ---------------------------------------------------------------------------
  // tests
  // ---------------------------------------------------------------------------

  initial begin
    reset          = 1'b1;
    clk7_en        = 1'b0;
    reg_address_in = NOP_ADDR;
    data_in        = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    begin_test();
    idle_ticks(20);  // outputs stay at 0
    end_test("reset and idle");

    begin_test();
    bus_tick(BPLCON0, 16'h0000);  // lores, single playfield
    bus_tick(BPLCON1, 16'h0000);
    load_planes();
    idle_ticks(40);  // 16 pixels at 2 ticks each
    end_test("lores single playfield");

    begin_test();
    bus_tick(BPLCON0, 16'h8000);  // hires
    gap_en = 1'b1;
    load_planes();
    idle_ticks(24);
    gap_en = 1'b0;
    end_test("hires with enable gaps");

    begin_test();
    bus_tick(BPLCON1, bus_word_t'($random(seed) & 8'hFF));  // both scroll fields
    load_planes();
    idle_ticks(40);  // 16 pixels plus up to 15 of delay
    end_test("scroll");

    begin_test();
    bus_tick(BPLCON0, 16'h8400);  // hires, dual playfield
    bus_tick(BPLCON2, 16'h0000);
    load_planes();
    idle_ticks(22);
    bus_tick(BPLCON2, 16'h0040);  // pf2 in front
    bus_tick(BPLCON1, 16'h0000);
    load_planes();
    idle_ticks(22);
    end_test("dual playfield priority");

    begin_test();
    bus_tick(BPLCON0, 16'h8000);
    bus_tick(BPLCON1, 16'h0031);
    load_planes();
    idle_ticks(6);  // first word still shifting
    bus_tick(BPLCON1, bus_word_t'($random(seed) & 8'hFF));
    load_planes();
    idle_ticks(36);
    end_test("back-to-back loads");

    idle_ticks(4);
    $display("checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+tb
hdl/denise_reg_pkg.sv
hdl/denise_video_pkg.sv
hdl/denise_bitplane_shifter.sv
hdl/denise_bitplanes.sv
hdl/denise_playfields.sv
hdl/denise_video.sv
tb/denise_video_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the playfield video testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module denise_video_tb \
  -f filelist.f \
  -o denise_video_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/denise_video_sim > sim.log 2>&1 \
  || echo "Simulation failed" >> sim.log

cat sim.log

grep -q "Simulation failed" sim.log \
  && { echo "result: failed"; exit 1; } \
  || { echo "result: passed"; exit 0; }
